//--- src/fetch_defs.svh
// widths are fixed at 32 bits; branch target math and the memory model rely on that
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// instruction word width
`define INST_W 32

// byte address width
`define ADDR_W 32

// first fetch address out of reset
`define RESET_VECTOR 32'h0000_0000

// flush target
// also used for jr since register values are not read
`define EXC_VECTOR 32'h0000_0180

// one bit per stage from pc up to wb
`define STALL_W 6

`endif

//--- src/isa_pkg.sv
// only the opcodes the fetch front end reacts to are named; all others decode as OP_OTHER
`include "fetch_defs.svh"

package isa_pkg;

    // one fetched instruction word
    typedef logic [`INST_W-1:0] inst_t;

    // one byte address
    typedef logic [`ADDR_W-1:0] addr_t;

    // major opcode field, bits 31:26
    typedef enum logic [5:0]
    {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        // stands for every opcode not listed above
        OP_OTHER   = 6'h3f
    } opcode_e;

    // function field under OP_SPECIAL
    // jr is the only one that moves the pc here
    typedef enum logic [5:0]
    {
        FN_JR = 6'h08
    } funct_e;

endpackage

//--- src/pipe_ctrl_pkg.sv
// stall bits are ordered from the pc stage at bit 0 up to writeback at bit 5
`include "fetch_defs.svh"

package pipe_ctrl_pkg;

    // set bit holds that stage
    typedef logic [`STALL_W-1:0] stall_vec_t;

    // bit positions inside stall_vec_t
    typedef enum logic [2:0]
    {
        STG_PC  = 3'd0,
        STG_IF  = 3'd1,
        STG_ID  = 3'd2,
        STG_EX  = 3'd3,
        STG_MEM = 3'd4,
        STG_WB  = 3'd5
    } stage_e;

endpackage

//--- src/pc_reg.sv
// flush overrides any redirect; a branch target is loaded only while the fetch port is idle
`include "fetch_defs.svh"

module pc_reg
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  pipe_ctrl_pkg::stall_vec_t stall,
    input  logic                      pc_ready,
    input  logic                      full,
    input  logic                      branch_flag,
    input  isa_pkg::addr_t            branch_target,
    output isa_pkg::addr_t            pc,
    output logic                      pc_take
);
    import pipe_ctrl_pkg::*;

    logic redirect;

    // port idle means the delay slot read of the branch in decode is back
    assign redirect = branch_flag && pc_ready;

    // accept strobe for the fetch port
    // a parked word holds fetch back until it has moved into decode
    // no sequential fetch in a redirect cycle, the target goes next
    assign pc_take = pc_ready
                   && !stall[STG_PC]
                   && !full
                   && !redirect
                   && !flush;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= `RESET_VECTOR;
        end
        else if (flush)
        begin
            // exception entry
            pc <= `EXC_VECTOR;
        end
        else if (redirect)
        begin
            // held branch may repeat this, same target every time
            pc <= branch_target;
        end
        else if (pc_take)
        begin
            pc <= pc + `ADDR_W'(4);
        end
    end

endmodule

//--- src/fetch_port.sv
// one read in flight; memory must answer every request, a flushed read is waited for and dropped
module fetch_port
(
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           pc_take,
    input  isa_pkg::addr_t pc,
    output logic           mem_req,
    output isa_pkg::addr_t mem_addr,
    input  logic           mem_rvalid,
    input  isa_pkg::inst_t mem_rdata,
    output logic           inst_valid,
    output logic           pc_ready,
    output isa_pkg::addr_t if_pc,
    output isa_pkg::inst_t if_inst
);
    import isa_pkg::*;

    typedef enum logic [1:0]
    {
        IDLE,
        REQ,
        WAIT,
        DROP
    } state_e;

    state_e state;
    state_e state_next;

    // address of the read in flight
    addr_t addr_q;

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
                if (pc_take)
                    state_next = REQ;
            REQ:
                // request leaves this cycle either way
                state_next = flush ? DROP : WAIT;
            WAIT:
                if (mem_rvalid)
                    state_next = IDLE;
                else if (flush)
                    state_next = DROP;
            DROP:
                // swallow the stale response
                if (mem_rvalid)
                    state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= IDLE;
            inst_valid <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            // one cycle pulse, one cycle after the memory answers
            inst_valid <= (state == WAIT) && mem_rvalid && !flush;
        end
    end

    // address and returned word
    always_ff @(posedge clk)
    begin
        if (state == IDLE && pc_take)
            addr_q <= pc;
        if (state == WAIT && mem_rvalid)
        begin
            if_inst <= mem_rdata;
            if_pc   <= addr_q;
        end
    end

    assign mem_req  = (state == REQ);
    assign mem_addr = addr_q;

    // idle port takes a new address, or lets a pending redirect through
    assign pc_ready = (state == IDLE);

endmodule

//--- src/if_id.sv
// one save slot only; the IF and ID stall bits are expected to rise and fall together
module if_id
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flush,
    input  pipe_ctrl_pkg::stall_vec_t stall,
    input  isa_pkg::addr_t            if_pc,
    input  isa_pkg::inst_t            if_inst,
    input  logic                      inst_valid,
    input  logic                      pc_ready,
    input  logic                      branch_flag,
    input  logic                      id_next_in_delay_slot,
    output isa_pkg::addr_t            id_pc,
    output isa_pkg::inst_t            id_inst,
    output logic                      id_in_delay_slot,
    output logic                      full,
    output logic                      stallreq_for_ex
);
    import isa_pkg::*;
    import pipe_ctrl_pkg::*;

    // fetch data is only meaningful with inst_valid
    addr_t if_pc_filtered;
    inst_t if_inst_filtered;

    // save slot
    addr_t saved_pc;
    inst_t saved_inst;
    logic  saved_ds;
    logic  saved;

    logic  inst_ready;
    logic  park;
    logic  release_slot;

    assign if_pc_filtered   = inst_valid ? if_pc : '0;
    assign if_inst_filtered = inst_valid ? if_inst : '0;

    // decode moves and nothing is parked
    assign inst_ready = !saved && !stall[STG_ID];

    // word arrives while fetch and decode both hold
    assign park = inst_valid && stall[STG_IF] && stall[STG_ID];

    // decode moves again with a parked word
    // the parked word goes first
    assign release_slot = saved && !stall[STG_ID];

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            id_pc            <= '0;
            id_inst          <= '0;
            id_in_delay_slot <= 1'b0;
        end
        else if (release_slot)
        begin
            id_pc            <= saved_pc;
            id_inst          <= saved_inst;
            id_in_delay_slot <= saved_ds;
        end
        else if (inst_ready)
        begin
            // zeros when fetch has nothing, i.e. a bubble
            id_pc            <= if_pc_filtered;
            id_inst          <= if_inst_filtered;
            // branch still in decode marks the word that follows it
            id_in_delay_slot <= inst_valid && id_next_in_delay_slot;
        end
        // otherwise decode holds
    end

    // slot occupancy
    always_ff @(posedge clk)
    begin
        if (reset || flush)
            saved <= 1'b0;
        else if (park)
            saved <= 1'b1;
        else if (release_slot)
            saved <= 1'b0;
    end

    // slot payload, delay slot flag travels with the word
    always_ff @(posedge clk)
    begin
        if (park)
        begin
            saved_pc   <= if_pc;
            saved_inst <= if_inst;
            saved_ds   <= id_next_in_delay_slot;
        end
    end

    // pc side stops fetching while this is high
    assign full = saved;

    // branch in decode waits until its delay slot read is back
    // holds decode and ex so the branch stays visible to the pc
    assign stallreq_for_ex = branch_flag && !pc_ready;

endmodule

//--- src/pipe_ctrl.sv
// only two stall sources exist here; mem and wb bits are never set
module pipe_ctrl
(
    input  logic                      decode_stall,
    input  logic                      stallreq_for_ex,
    output pipe_ctrl_pkg::stall_vec_t stall
);
    import pipe_ctrl_pkg::*;

    always_comb
    begin
        // later stages keep running
        stall = '0;
        if (stallreq_for_ex)
        begin
            // deeper request, holds ex as well
            stall[STG_PC] = 1'b1;
            stall[STG_IF] = 1'b1;
            stall[STG_ID] = 1'b1;
            stall[STG_EX] = 1'b1;
        end
        else if (decode_stall)
        begin
            // everything up to and including decode
            stall[STG_PC] = 1'b1;
            stall[STG_IF] = 1'b1;
            stall[STG_ID] = 1'b1;
        end
    end

endmodule

//--- src/branch_resolve.sv
// registers are not read, so rs and rt numbers stand in for their values and jr targets EXC_VECTOR
`include "fetch_defs.svh"

module branch_resolve
(
    input  isa_pkg::addr_t id_pc,
    input  isa_pkg::inst_t id_inst,
    output logic           branch_flag,
    output logic           next_in_delay_slot,
    output isa_pkg::addr_t branch_target
);
    import isa_pkg::*;

    opcode_e     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [5:0]  funct;
    logic [15:0] imm;
    logic [25:0] index;
    addr_t       pc_plus4;
    addr_t       pc_plus8;
    addr_t       br_target;
    addr_t       jmp_target;

    // instruction fields
    assign rs    = id_inst[25:21];
    assign rt    = id_inst[20:16];
    assign funct = id_inst[5:0];
    assign imm   = id_inst[15:0];
    assign index = id_inst[25:0];

    assign pc_plus4 = id_pc + `ADDR_W'(4);
    // fall through past the delay slot
    assign pc_plus8 = id_pc + `ADDR_W'(8);

    // conditional branch, word offset from the delay slot
    assign br_target  = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    // jump inside the current 256 MB region
    assign jmp_target = {pc_plus4[31:28], index, 2'b00};

    always_comb
    begin
        case (id_inst[31:26])
            OP_SPECIAL: op = OP_SPECIAL;
            OP_J:       op = OP_J;
            OP_JAL:     op = OP_JAL;
            OP_BEQ:     op = OP_BEQ;
            OP_BNE:     op = OP_BNE;
            default:    op = OP_OTHER;
        endcase
    end

    // a zero word is special sll, never a transfer
    always_comb
    begin
        branch_flag   = 1'b0;
        branch_target = pc_plus8;
        case (op)
            OP_J, OP_JAL:
            begin
                branch_flag   = 1'b1;
                branch_target = jmp_target;
            end
            OP_BEQ:
            begin
                branch_flag = 1'b1;
                if (rs == rt)
                    branch_target = br_target;
            end
            OP_BNE:
            begin
                branch_flag = 1'b1;
                if (rs != rt)
                    branch_target = br_target;
            end
            OP_SPECIAL:
                if (funct == FN_JR)
                begin
                    branch_flag   = 1'b1;
                    branch_target = `EXC_VECTOR;
                end
            default:
                branch_flag = 1'b0;
        endcase
    end

    // taken or not, every transfer has a delay slot
    assign next_in_delay_slot = branch_flag;

endmodule

//--- src/fetch_top.sv
// memory must answer every request exactly once, including one issued just before a flush
module fetch_top
(
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           decode_stall,
    input  logic           mem_rvalid,
    input  isa_pkg::inst_t mem_rdata,
    output logic           mem_req,
    output isa_pkg::addr_t mem_addr,
    output isa_pkg::addr_t id_pc,
    output isa_pkg::inst_t id_inst,
    output logic           id_in_delay_slot
);
    import isa_pkg::*;
    import pipe_ctrl_pkg::*;

    // pc side
    addr_t      pc;
    logic       pc_take;
    logic       pc_ready;
    // fetch to if_id
    logic       inst_valid;
    addr_t      if_pc;
    inst_t      if_inst;
    logic       full;
    // decode and stall control
    stall_vec_t stall;
    logic       stallreq_for_ex;
    logic       branch_flag;
    addr_t      branch_target;
    logic       id_next_in_delay_slot;

    pc_reg i_pc_reg
    (
        .clk           (clk),
        .reset         (reset),
        .flush         (flush),
        .stall         (stall),
        .pc_ready      (pc_ready),
        .full          (full),
        .branch_flag   (branch_flag),
        .branch_target (branch_target),
        .pc            (pc),
        .pc_take       (pc_take)
    );

    fetch_port i_fetch_port
    (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .pc_take    (pc_take),
        .pc         (pc),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .inst_valid (inst_valid),
        .pc_ready   (pc_ready),
        .if_pc      (if_pc),
        .if_inst    (if_inst)
    );

    if_id i_if_id
    (
        .clk                   (clk),
        .reset                 (reset),
        .flush                 (flush),
        .stall                 (stall),
        .if_pc                 (if_pc),
        .if_inst               (if_inst),
        .inst_valid            (inst_valid),
        .pc_ready              (pc_ready),
        .branch_flag           (branch_flag),
        .id_next_in_delay_slot (id_next_in_delay_slot),
        .id_pc                 (id_pc),
        .id_inst               (id_inst),
        .id_in_delay_slot      (id_in_delay_slot),
        .full                  (full),
        .stallreq_for_ex       (stallreq_for_ex)
    );

    pipe_ctrl i_pipe_ctrl
    (
        .decode_stall    (decode_stall),
        .stallreq_for_ex (stallreq_for_ex),
        .stall           (stall)
    );

    branch_resolve i_branch_resolve
    (
        .id_pc              (id_pc),
        .id_inst            (id_inst),
        .branch_flag        (branch_flag),
        .next_in_delay_slot (id_next_in_delay_slot),
        .branch_target      (branch_target)
    );

endmodule

//--- verification/fetch_mem_model.sv
// 1024 words indexed by address bits 11:2, one read at a time, every request gets an answer
module fetch_mem_model
(
    input  logic           clk,
    input  logic           reset,
    input  logic           mem_req,
    input  isa_pkg::addr_t mem_addr,
    input  logic [2:0]     lat_fixed,
    input  logic           lat_random,
    output logic           mem_rvalid,
    output isa_pkg::inst_t mem_rdata
);
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;

    localparam int WORDS = 1024;

    // written directly by the testbench
    inst_t mem [0:WORDS-1];

    integer seed = 32'h457bb90d;
    logic   busy;
    addr_t  pend_addr;
    int     remaining;
    int     lat_now;

    // request to answer in cycles, never below one
    function automatic int pick_latency();
        int lat;
        if (lat_random)
            lat = ($unsigned($random(seed)) % 6) + 1;
        else
            lat = (lat_fixed == 3'd0) ? 1 : int'(lat_fixed);
        return lat;
    endfunction

    always @(posedge clk)
    begin
        mem_rvalid <= 1'b0;
        if (reset)
        begin
            busy <= 1'b0;
        end
        else if (busy)
        begin
            if (remaining <= 1)
            begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= mem[pend_addr[11:2]];
                busy       <= 1'b0;
            end
            else
                remaining <= remaining - 1;
        end
        else if (mem_req)
        begin
            lat_now = pick_latency();
            // latency one answers in the cycle right after the request
            if (lat_now == 1)
            begin
                mem_rvalid <= 1'b1;
                mem_rdata  <= mem[mem_addr[11:2]];
            end
            else
            begin
                busy      <= 1'b1;
                pend_addr <= mem_addr;
                remaining <= lat_now - 1;
            end
        end
    end

endmodule

//--- verification/fetch_tb.sv
// image wraps every 4 KB; test programs never put a control transfer into a delay slot
`include "fetch_defs.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import isa_pkg::*;

    localparam int WORDS = 1024;

    logic       clk;
    logic       reset;
    logic       flush;
    logic       decode_stall;
    logic       mem_req;
    addr_t      mem_addr;
    logic       mem_rvalid;
    inst_t      mem_rdata;
    addr_t      id_pc;
    inst_t      id_inst;
    logic       id_in_delay_slot;
    logic [2:0] lat_fixed;
    logic       lat_random;

    // reference copy of the program image
    inst_t image [0:WORDS-1];

    // nonzero decode words since the last clear
    addr_t got_pc[$];
    inst_t got_inst[$];
    logic  got_ds[$];
    // read addresses seen on the memory port since the last clear
    addr_t got_req[$];
    addr_t last_pc;
    inst_t last_inst;
    logic  last_ds;

    int check_count;
    int error_count;
    int timeout_count;

    fetch_top i_fetch_top
    (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .decode_stall     (decode_stall),
        .mem_rvalid       (mem_rvalid),
        .mem_rdata        (mem_rdata),
        .mem_req          (mem_req),
        .mem_addr         (mem_addr),
        .id_pc            (id_pc),
        .id_inst          (id_inst),
        .id_in_delay_slot (id_in_delay_slot)
    );

    fetch_mem_model i_mem_model
    (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .lat_fixed  (lat_fixed),
        .lat_random (lat_random),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // decode and memory port sampled mid cycle, a held word is recorded once
    always @(negedge clk)
    begin
        if (!reset && mem_req)
            got_req.push_back(mem_addr);
        if (!reset && id_inst != '0
            && (id_pc != last_pc || id_inst != last_inst || id_in_delay_slot != last_ds))
        begin
            got_pc.push_back(id_pc);
            got_inst.push_back(id_inst);
            got_ds.push_back(id_in_delay_slot);
        end
        last_pc   = id_pc;
        last_inst = id_inst;
        last_ds   = id_in_delay_slot;
    end

    // addi style filler, never a transfer, unique per word
    function automatic inst_t fill_word(addr_t a);
        return {6'h08, 16'h0000, a[11:2]};
    endfunction

    function automatic logic is_transfer(inst_t w);
        case (w[31:26])
            OP_J, OP_JAL, OP_BEQ, OP_BNE:
                return 1'b1;
            OP_SPECIAL:
                return w[5:0] == FN_JR;
            default:
                return 1'b0;
        endcase
    endfunction

    // where fetch continues after the delay slot
    function automatic addr_t target_of(addr_t pc, inst_t w);
        addr_t seq4;
        addr_t offset;
        seq4   = pc + 32'd4;
        offset = {{14{w[15]}}, w[15:0], 2'b00};
        case (w[31:26])
            OP_J, OP_JAL:
                return {seq4[31:28], w[25:0], 2'b00};
            OP_BEQ:
                return (w[25:21] == w[20:16]) ? seq4 + offset : pc + 32'd8;
            OP_BNE:
                return (w[25:21] != w[20:16]) ? seq4 + offset : pc + 32'd8;
            default:
                // jr, registers are not read
                return `EXC_VECTOR;
        endcase
    endfunction

    task automatic compare_value(string what, logic [31:0] got, logic [31:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            error_count++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic place_word(addr_t a, inst_t w);
        image[a[11:2]] = w;
        i_mem_model.mem[a[11:2]] = w;
    endtask

    task automatic load_fill();
        int i;
        for (i = 0; i < WORDS; i++)
            place_word(addr_t'(i * 4), fill_word(addr_t'(i * 4)));
    endtask

    task automatic clear_collected();
        got_pc.delete();
        got_inst.delete();
        got_ds.delete();
        got_req.delete();
    endtask

    task automatic begin_reset(logic [2:0] lat, logic rnd);
        @(posedge clk);
        reset        <= 1'b1;
        flush        <= 1'b0;
        decode_stall <= 1'b0;
        lat_fixed    <= lat;
        lat_random   <= rnd;
    endtask

    // sixteen cycles in all, outputs checked just before release
    task automatic end_reset();
        repeat (15) @(posedge clk);
        @(negedge clk);
        compare_value("mem_req in reset", mem_req, 1'b0);
        compare_value("id_pc in reset", id_pc, '0);
        compare_value("id_inst in reset", id_inst, '0);
        compare_value("delay slot flag in reset", id_in_delay_slot, 1'b0);
        clear_collected();
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_words(int n, int limit);
        int cycles;
        cycles = 0;
        while (got_pc.size() < n && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (got_pc.size() < n)
        begin
            timeout_count++;
            $display("Timeout: only %0d of %0d decode words arrived within %0d cycles",
                     got_pc.size(), n, limit);
        end
    endtask

    // walks the image from start_pc by the pc+4, delay slot and target rules
    task automatic check_sequence(addr_t start_pc, int n);
        addr_t exp_pc;
        addr_t next_pc;
        addr_t pend_target;
        inst_t exp_inst;
        logic  prev_br;
        logic  cur_br;
        int    i;
        exp_pc      = start_pc;
        pend_target = '0;
        prev_br     = 1'b0;
        for (i = 0; i < n && i < got_pc.size(); i++)
        begin
            exp_inst = image[exp_pc[11:2]];
            compare_value("decode pc", got_pc[i], exp_pc);
            compare_value("decode word", got_inst[i], exp_inst);
            compare_value("delay slot flag", got_ds[i], prev_br);
            cur_br = is_transfer(exp_inst);
            // past the delay slot fetch goes to the target
            next_pc = prev_br ? pend_target : exp_pc + 32'd4;
            if (cur_br)
                pend_target = target_of(exp_pc, exp_inst);
            prev_br = cur_br;
            exp_pc  = next_pc;
        end
    endtask

    // straight code reads one word address after the other
    task automatic match_requests(addr_t start_pc, int n);
        int i;
        for (i = 0; i < n && i < got_req.size(); i++)
            compare_value("request address", got_req[i], start_pc + 32'd4 * i);
    endtask

    task automatic straight_fetch(logic [2:0] lat, logic rnd);
        begin_reset(lat, rnd);
        load_fill();
        end_reset();
        wait_words(12, 300);
        check_sequence(`RESET_VECTOR, 12);
        match_requests(`RESET_VECTOR, 12);
    endtask

    task automatic stalled_decode();
        addr_t held_pc;
        inst_t held_inst;
        int    cycles;
        begin_reset(3'd1, 1'b0);
        load_fill();
        end_reset();
        wait_words(3, 100);
        @(posedge clk);
        decode_stall <= 1'b1;
        @(negedge clk);
        held_pc   = id_pc;
        held_inst = id_inst;
        // long enough for the read in flight to be parked
        for (cycles = 0; cycles < 10; cycles++)
        begin
            @(negedge clk);
            compare_value("held id_pc", id_pc, held_pc);
            compare_value("held id_inst", id_inst, held_inst);
        end
        @(posedge clk);
        decode_stall <= 1'b0;
        wait_words(12, 300);
        check_sequence(`RESET_VECTOR, 12);
    endtask

    task automatic branch_program();
        addr_t walk [0:13];
        int    i;
        walk = '{32'h00, 32'h04, 32'h08, 32'h40, 32'h44, 32'h48, 32'h80,
                 32'h84, 32'h88, 32'h8c, 32'h100, 32'h104, 32'h108, 32'h10c};
        begin_reset(3'd2, 1'b0);
        load_fill();
        // j 0x40
        place_word(32'h04, {OP_J, 26'h10});
        // beq r1, r1, taken to 0x80
        place_word(32'h44, {OP_BEQ, 5'd1, 5'd1, 16'd14});
        // bne r2, r2, falls through to 0x88
        place_word(32'h80, {OP_BNE, 5'd2, 5'd2, 16'h0010});
        // jal 0x100
        place_word(32'h88, {OP_JAL, 26'h40});
        end_reset();
        wait_words(14, 400);
        check_sequence(`RESET_VECTOR, 14);
        for (i = 0; i < 14 && i < got_pc.size(); i++)
            compare_value("branch walk pc", got_pc[i], walk[i]);
    endtask

    task automatic flush_during_read();
        int cycles;
        begin_reset(3'd6, 1'b0);
        load_fill();
        end_reset();
        wait_words(2, 200);
        // next memory answer, its word reaches decode two cycles later
        cycles = 0;
        @(negedge clk);
        while (!mem_rvalid && cycles < 50)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!mem_rvalid)
        begin
            timeout_count++;
            $display("Timeout: no memory answer seen before the flush");
        end
        @(posedge clk);
        @(posedge clk);
        // decode keeps that word while the next slow read goes out
        decode_stall <= 1'b1;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush        <= 1'b0;
        decode_stall <= 1'b0;
        @(negedge clk);
        compare_value("id_pc after flush", id_pc, '0);
        compare_value("id_inst after flush", id_inst, '0);
        compare_value("delay slot flag after flush", id_in_delay_slot, 1'b0);
        clear_collected();
        wait_words(6, 300);
        check_sequence(`EXC_VECTOR, 6);
        match_requests(`EXC_VECTOR, 6);
    endtask

    initial
    begin
        reset         = 1'b1;
        flush         = 1'b0;
        decode_stall  = 1'b0;
        lat_fixed     = 3'd1;
        lat_random    = 1'b0;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        straight_fetch(3'd1, 1'b0);
        straight_fetch(3'd1, 1'b1);
        stalled_decode();
        branch_program();
        flush_during_read();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- fetch_frontend.f
+incdir+src
src/isa_pkg.sv
src/pipe_ctrl_pkg.sv
src/pc_reg.sv
src/fetch_port.sv
src/if_id.sv
src/pipe_ctrl.sv
src/branch_resolve.sv
src/fetch_top.sv
verification/fetch_mem_model.sv
verification/fetch_tb.sv
